// File: sim.f
cache_types_pkg.sv
cache_ctrl_pkg.sv
line_array.sv
l2_cache_datapath.sv
l2_cache_control.sv
l2_cache_top.sv
l2_cache_assertions.sv
tb_l2_cache.sv

// File: tb_l2_cache.sv
module tb_l2_cache;

	localparam int num_requests = 16;
	localparam int worst_cycles = 16; // lookup, writeback 4, fill 4, lookup, respond, gaps
	localparam int cycle_limit = num_requests * worst_cycles + 3 + 100;

	logic clk;
	logic rst;
	logic mem_read;
	logic mem_write;
	cache_types_pkg::word_t mem_address;
	cache_types_pkg::line_t mem_wdata;
	cache_types_pkg::line_t mem_rdata;
	logic mem_resp;
	cache_types_pkg::line_t pmem_rdata;
	logic pmem_resp;
	logic pmem_read;
	logic pmem_write;
	cache_types_pkg::word_t pmem_address;
	cache_types_pkg::line_t pmem_wdata;

	cache_types_pkg::line_t phys_mem [cache_types_pkg::word_t];
	logic [15:0] lfsr = 16'd46072;
	int cycles = 0;
	int timeouts = 0;

	l2_cache_top l2_cache_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(logic [15:0] value);
		return value[0] ? ((value >> 1) ^ 16'hb400) : (value >> 1);
	endfunction

	task automatic take_bits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			lfsr = lfsr_next(lfsr);
			value = (value << 1) | lfsr[0];
		end
	endtask

	// every word mixes the full line address with its position
	function automatic cache_types_pkg::line_t line_pattern(cache_types_pkg::word_t addr);
		cache_types_pkg::line_t value;
		for (int i = 0; i < 8; i++) begin
			value[32*i +: 32] = {addr[15:0], addr[31:16]} ^ (32'h9e3779b9 * (i + 1));
		end
		return value;
	endfunction

	// physical memory answers after 1 to 4 cycles
	always begin : memory_model
		int delay;
		@(negedge clk);
		if (!rst && (pmem_read || pmem_write)) begin
			take_bits(2, delay);
			repeat (delay) @(negedge clk);
			if (pmem_write) begin
				phys_mem[pmem_address] = pmem_wdata;
			end else if (phys_mem.exists(pmem_address)) begin
				pmem_rdata = phys_mem[pmem_address];
			end else begin
				pmem_rdata = line_pattern(pmem_address);
			end
			pmem_resp = 1'b1;
			@(negedge clk);
			pmem_resp = 1'b0;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			timeouts++;
			$display("timeout: the cache stopped answering after %0d cycles", cycles);
			$display("closing: %0d assertion failures, %0d timeouts",
				l2_cache_top_inst.assertions_inst.fail_count, timeouts);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic access(input logic write, input cache_types_pkg::word_t addr,
		input cache_types_pkg::line_t data);
		mem_read = ~write;
		mem_write = write;
		mem_address = addr;
		mem_wdata = data;
		do begin
			@(negedge clk);
		end while (!mem_resp);
		@(negedge clk); // hold through the responding edge
		mem_read = 1'b0;
		mem_write = 1'b0;
	endtask

	initial begin
		cache_types_pkg::word_t a;
		cache_types_pkg::word_t b;
		cache_types_pkg::word_t c;
		a = 32'h0000_1040; // a, b and c share set 2
		b = 32'h0000_2040;
		c = 32'h0000_3040;
		rst = 1'b1;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_address = '0;
		mem_wdata = '0;
		pmem_rdata = '0;
		pmem_resp = 1'b0;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		access(1'b0, 32'h0000_0100, '0); // cold read
		access(1'b0, 32'h0000_0108, '0); // same line, hit
		access(1'b1, a, {8{32'h1111_aaaa}});
		access(1'b0, a, '0);
		access(1'b1, b, {8{32'h2222_bbbb}});
		access(1'b0, b, '0);
		access(1'b0, c, '0); // dirty a goes back
		access(1'b0, b, '0);
		access(1'b0, a, '0); // evicts clean c
		access(1'b0, b, '0);
		access(1'b0, a, '0);
		access(1'b0, c, '0); // evicts dirty b
		access(1'b0, a, '0);
		access(1'b0, 32'h0000_00a0, '0);
		access(1'b0, 32'h0000_10a0, '0);
		access(1'b0, 32'h0000_20a0, '0); // clean victim

		repeat (4) @(negedge clk);
		$display("closing: %0d assertion failures, %0d timeouts",
			l2_cache_top_inst.assertions_inst.fail_count, timeouts);
		if (l2_cache_top_inst.assertions_inst.fail_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule : tb_l2_cache

// File: l2_cache_assertions.sv
module l2_cache_assertions #(
	parameter int s_index = 3
) (
	input logic clk,
	input logic rst,
	input logic mem_read,
	input logic mem_write,
	input cache_types_pkg::word_t mem_address,
	input cache_types_pkg::line_t mem_wdata,
	input cache_types_pkg::line_t mem_rdata,
	input logic mem_resp,
	input cache_types_pkg::line_t pmem_rdata,
	input logic pmem_resp,
	input logic pmem_read,
	input logic pmem_write,
	input cache_types_pkg::word_t pmem_address,
	input cache_types_pkg::line_t pmem_wdata,
	input cache_ctrl_pkg::ctrl_state_e state
);

	localparam int num_sets = 2 ** s_index;

	int fail_count = 0;

	// each set keeps its most recently used line and the other one
	cache_types_pkg::word_t mru_line [num_sets];
	cache_types_pkg::word_t other_line [num_sets];
	cache_types_pkg::line_t mru_data [num_sets];
	cache_types_pkg::line_t other_data [num_sets];
	logic mru_valid [num_sets];
	logic other_valid [num_sets];
	logic mru_dirty [num_sets];
	logic other_dirty [num_sets];
	cache_types_pkg::line_t fill_data;

	int set;
	cache_types_pkg::word_t line;
	logic in_mru;
	logic in_other;
	logic resident;
	logic victim_dirty;
	logic request;
	cache_types_pkg::line_t exp_rdata;

	always_comb begin
		set = int'(cache_types_pkg::addr_index(mem_address, s_index));
		line = cache_types_pkg::line_base(mem_address);
		in_mru = mru_valid[set] && (mru_line[set] == line);
		in_other = other_valid[set] && (other_line[set] == line);
		resident = in_mru || in_other;
		victim_dirty = other_valid[set] && other_dirty[set];
		request = mem_read || mem_write;
		if (in_mru) begin
			exp_rdata = mru_data[set];
		end else if (in_other) begin
			exp_rdata = other_data[set];
		end else begin
			exp_rdata = fill_data; // line just brought in
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < num_sets; i++) begin
				mru_valid[i] <= 1'b0;
				other_valid[i] <= 1'b0;
				mru_dirty[i] <= 1'b0;
				other_dirty[i] <= 1'b0;
			end
			fill_data <= '0;
		end else begin
			if (pmem_read && pmem_resp) begin
				fill_data <= pmem_rdata;
			end
			if (mem_resp && in_mru) begin
				if (mem_write) begin
					mru_data[set] <= mem_wdata;
					mru_dirty[set] <= 1'b1;
				end
			end else if (mem_resp) begin
				other_line[set] <= mru_line[set]; // old mru becomes the victim
				other_valid[set] <= mru_valid[set];
				other_data[set] <= mru_data[set];
				other_dirty[set] <= mru_dirty[set];
				mru_line[set] <= line;
				mru_valid[set] <= 1'b1;
				mru_data[set] <= mem_write ? mem_wdata : exp_rdata;
				mru_dirty[set] <= mem_write | (in_other & other_dirty[set]);
			end
		end
	end

	read_data: assert property (@(posedge clk) disable iff (rst)
		(mem_read && mem_resp) |-> (mem_rdata == exp_rdata))
		else begin
			fail_count++;
			$error("ERROR %0t mem_rdata got %h expected %h", $time, mem_rdata, exp_rdata);
		end

	victim_addr: assert property (@(posedge clk) disable iff (rst)
		pmem_write |-> (other_valid[set] && pmem_address == other_line[set]))
		else begin
			fail_count++;
			$error("ERROR %0t pmem_address got %h expected %h", $time, pmem_address,
				other_line[set]);
		end

	victim_data: assert property (@(posedge clk) disable iff (rst)
		pmem_write |-> (pmem_wdata == other_data[set]))
		else begin
			fail_count++;
			$error("ERROR %0t pmem_wdata got %h expected %h", $time, pmem_wdata,
				other_data[set]);
		end

	fill_addr: assert property (@(posedge clk) disable iff (rst)
		pmem_read |-> (pmem_address == line))
		else begin
			fail_count++;
			$error("ERROR %0t pmem_address got %h expected %h", $time, pmem_address, line);
		end

	hit_latency: assert property (@(posedge clk) disable iff (rst)
		(state == cache_ctrl_pkg::idle && request && resident) |-> ##2 mem_resp)
		else begin
			fail_count++;
			$error("hit on a resident line did not respond two cycles after the request");
		end

	hit_quiet: assert property (@(posedge clk) disable iff (rst)
		(state == cache_ctrl_pkg::idle && request && resident)
			|-> (!pmem_read && !pmem_write) [*3])
		else begin
			fail_count++;
			$error("physical memory was accessed during a hit");
		end

	clean_miss: assert property (@(posedge clk) disable iff (rst)
		(state == cache_ctrl_pkg::idle && request && !resident && !victim_dirty)
			|-> (!pmem_write throughout mem_resp [->1]))
		else begin
			fail_count++;
			$error("a miss with a clean victim wrote back to physical memory");
		end

	miss_fill: assert property (@(posedge clk) disable iff (rst)
		(state == cache_ctrl_pkg::idle && request && !resident)
			|-> (!mem_resp throughout pmem_read [->1]))
		else begin
			fail_count++;
			$error("a miss responded without reading the line from physical memory");
		end

	exclusive: assert property (@(posedge clk) !(pmem_read && pmem_write))
		else begin
			fail_count++;
			$error("pmem_read and pmem_write were high together");
		end

	reset_state: assert property (@(posedge clk)
		$fell(rst) |-> (!mem_resp && !pmem_read && !pmem_write))
		else begin
			fail_count++;
			$error("outputs were not low after reset");
		end

endmodule : l2_cache_assertions

bind l2_cache_top l2_cache_assertions #(.s_index(s_index)) assertions_inst (
	.*,
	.state(control_inst.state)
);

// File: l2_cache_top.sv
module l2_cache_top #(
	parameter int s_index = 3
) (
	input logic clk,
	input logic rst,

	input logic mem_read,
	input logic mem_write,
	input cache_types_pkg::word_t mem_address,
	input cache_types_pkg::line_t mem_wdata,
	output cache_types_pkg::line_t mem_rdata,
	output logic mem_resp,

	input cache_types_pkg::line_t pmem_rdata,
	input logic pmem_resp,
	output logic pmem_read,
	output logic pmem_write,
	output cache_types_pkg::word_t pmem_address,
	output cache_types_pkg::line_t pmem_wdata
);

	cache_ctrl_pkg::ctrl_t ctrl;
	cache_ctrl_pkg::stat_t stat;

	l2_cache_control control_inst (
		.clk(clk),
		.rst(rst),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.pmem_resp(pmem_resp),
		.stat(stat),
		.ctrl(ctrl),
		.mem_resp(mem_resp),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write)
	);

	l2_cache_datapath #(.s_index(s_index)) datapath_inst (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.stat(stat),
		.mem_address(mem_address),
		.mem_wdata(mem_wdata),
		.pmem_rdata(pmem_rdata),
		.mem_rdata(mem_rdata),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata)
	);

endmodule : l2_cache_top

// File: l2_cache_control.sv
module l2_cache_control (
	input logic clk,
	input logic rst,
	input logic mem_read,
	input logic mem_write,
	input logic pmem_resp,
	input cache_ctrl_pkg::stat_t stat,
	output cache_ctrl_pkg::ctrl_t ctrl,
	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write
);

	cache_ctrl_pkg::ctrl_state_e state;
	cache_ctrl_pkg::ctrl_state_e next_state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= cache_ctrl_pkg::idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		ctrl = '0;
		ctrl.din_sel = cache_ctrl_pkg::din_pmem;
		ctrl.paddr_sel = cache_ctrl_pkg::paddr_mem;
		mem_resp = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;

		unique case (state)
			cache_ctrl_pkg::idle: begin
				if (mem_read || mem_write) begin
					next_state = cache_ctrl_pkg::lookup;
				end
			end

			cache_ctrl_pkg::lookup: begin
				ctrl.read_arrays = 1'b1; // stat valid next cycle
				next_state = cache_ctrl_pkg::respond;
			end

			cache_ctrl_pkg::respond: begin
				if (stat.hit) begin
					mem_resp = 1'b1;
					ctrl.load_lru = 1'b1;
					if (mem_write) begin
						ctrl.din_sel = cache_ctrl_pkg::din_mem;
						ctrl.load_data[stat.hit_way] = 1'b1;
						ctrl.set_dirty[stat.hit_way] = 1'b1;
					end
					next_state = cache_ctrl_pkg::idle;
				end else if (stat.victim_dirty) begin
					next_state = cache_ctrl_pkg::writeback;
				end else begin
					next_state = cache_ctrl_pkg::fill; // clean victim is dropped
				end
			end

			cache_ctrl_pkg::writeback: begin
				pmem_write = 1'b1;
				ctrl.paddr_sel = cache_ctrl_pkg::paddr_victim;
				if (pmem_resp) begin
					next_state = cache_ctrl_pkg::fill;
				end
			end

			cache_ctrl_pkg::fill: begin
				pmem_read = 1'b1;
				ctrl.paddr_sel = cache_ctrl_pkg::paddr_mem;
				if (pmem_resp) begin
					ctrl.din_sel = cache_ctrl_pkg::din_pmem;
					ctrl.load_data[stat.lru_way] = 1'b1;
					ctrl.load_tag[stat.lru_way] = 1'b1;
					ctrl.set_valid[stat.lru_way] = 1'b1;
					ctrl.clear_dirty[stat.lru_way] = 1'b1;
					next_state = cache_ctrl_pkg::lookup; // re-lookup now hits
				end
			end

			default: begin
				next_state = cache_ctrl_pkg::idle;
			end
		endcase
	end

endmodule : l2_cache_control

// File: l2_cache_datapath.sv
module l2_cache_datapath #(
	parameter int s_index = 3
) (
	input logic clk,
	input logic rst,
	input cache_ctrl_pkg::ctrl_t ctrl,
	output cache_ctrl_pkg::stat_t stat,
	input cache_types_pkg::word_t mem_address,
	input cache_types_pkg::line_t mem_wdata,
	input cache_types_pkg::line_t pmem_rdata,
	output cache_types_pkg::line_t mem_rdata,
	output cache_types_pkg::word_t pmem_address,
	output cache_types_pkg::line_t pmem_wdata
);

	typedef logic [s_index-1:0] index_t;

	index_t index;
	index_t kept_index;
	cache_types_pkg::word_t tag_in;
	cache_types_pkg::word_t victim_addr;
	cache_types_pkg::line_t datain;
	cache_types_pkg::line_t data_out [2];
	cache_types_pkg::word_t tag_out [2];
	logic [1:0] valid_out;
	logic [1:0] dirty_out;
	logic [1:0] load_dirty;
	logic [1:0] tag_hit;
	logic lru_out;
	logic lru_in;

	assign index = index_t'(cache_types_pkg::addr_index(mem_address, s_index));
	assign tag_in = cache_types_pkg::addr_tag(mem_address, s_index);

	always_comb begin
		unique case (ctrl.din_sel)
			cache_ctrl_pkg::din_mem: datain = mem_wdata;
			default: datain = pmem_rdata;
		endcase
	end

	for (genvar w = 0; w < 2; w++) begin : g_way
		assign load_dirty[w] = ctrl.set_dirty[w] | ctrl.clear_dirty[w];
		assign tag_hit[w] = valid_out[w] && (tag_out[w] == tag_in);

		line_array #(.s_index(s_index), .payload_t(cache_types_pkg::line_t)) data_inst (
			.clk(clk),
			.rst(rst),
			.read(ctrl.read_arrays),
			.load(ctrl.load_data[w]),
			.rindex(index),
			.windex(index),
			.datain(datain),
			.dataout(data_out[w])
		);

		line_array #(.s_index(s_index), .payload_t(cache_types_pkg::word_t)) tag_inst (
			.clk(clk),
			.rst(rst),
			.read(ctrl.read_arrays),
			.load(ctrl.load_tag[w]),
			.rindex(index),
			.windex(index),
			.datain(tag_in),
			.dataout(tag_out[w])
		);

		line_array #(.s_index(s_index), .payload_t(logic)) valid_inst (
			.clk(clk),
			.rst(rst),
			.read(ctrl.read_arrays),
			.load(ctrl.set_valid[w]),
			.rindex(index),
			.windex(index),
			.datain(1'b1),
			.dataout(valid_out[w])
		);

		line_array #(.s_index(s_index), .payload_t(logic)) dirty_inst (
			.clk(clk),
			.rst(rst),
			.read(ctrl.read_arrays),
			.load(load_dirty[w]),
			.rindex(index),
			.windex(index),
			.datain(ctrl.set_dirty[w]), // set wins, clear writes zero
			.dataout(dirty_out[w])
		);
	end

	assign lru_in = ~stat.hit_way; // point at the way not just used

	line_array #(.s_index(s_index), .payload_t(logic)) lru_inst (
		.clk(clk),
		.rst(rst),
		.read(ctrl.read_arrays),
		.load(ctrl.load_lru),
		.rindex(index),
		.windex(index),
		.datain(lru_in),
		.dataout(lru_out)
	);

	// single entry, captured at lookup for the write-back address
	line_array #(.s_index(1), .payload_t(index_t)) kept_index_inst (
		.clk(clk),
		.rst(rst),
		.read(1'b1),
		.load(ctrl.read_arrays),
		.rindex(1'b0),
		.windex(1'b0),
		.datain(index),
		.dataout(kept_index)
	);

	assign stat.hit = |tag_hit;
	assign stat.hit_way = tag_hit[1];
	assign stat.lru_way = lru_out;
	assign stat.victim_dirty = dirty_out[lru_out];

	assign mem_rdata = data_out[tag_hit[1]];
	assign pmem_wdata = data_out[lru_out];
	assign victim_addr = cache_types_pkg::line_base(cache_types_pkg::join_addr(
		tag_out[lru_out], cache_types_pkg::word_t'(kept_index), s_index));

	always_comb begin
		unique case (ctrl.paddr_sel)
			cache_ctrl_pkg::paddr_victim: pmem_address = victim_addr;
			default: pmem_address = cache_types_pkg::line_base(mem_address);
		endcase
	end

endmodule : l2_cache_datapath

// File: line_array.sv
module line_array #(
	parameter int s_index = 3,
	parameter type payload_t = logic
) (
	input logic clk,
	input logic rst,
	input logic read,
	input logic load,
	input logic [s_index-1:0] rindex,
	input logic [s_index-1:0] windex,
	input payload_t datain,
	output payload_t dataout
);

	localparam int num_sets = 2 ** s_index;

	payload_t data [num_sets];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < num_sets; i++) begin
				data[i] <= '0;
			end
			dataout <= '0;
		end else begin
			if (read) begin
				dataout <= data[rindex]; // old value on same-cycle write
			end
			if (load) begin
				data[windex] <= datain;
			end
		end
	end

endmodule : line_array

// File: cache_ctrl_pkg.sv
package cache_ctrl_pkg;

	typedef enum logic [2:0] {
		idle,
		lookup,
		writeback,
		fill,
		respond
	} ctrl_state_e;

	typedef enum logic {
		din_pmem = 1'b0, // fill from physical memory
		din_mem = 1'b1   // write data from the requester
	} din_sel_e;

	typedef enum logic {
		paddr_mem = 1'b0,
		paddr_victim = 1'b1
	} paddr_sel_e;

	typedef struct packed {
		logic read_arrays;
		logic [1:0] load_data;
		logic [1:0] load_tag;
		logic [1:0] set_valid;
		logic [1:0] set_dirty;
		logic [1:0] clear_dirty;
		logic load_lru;
		din_sel_e din_sel;
		paddr_sel_e paddr_sel;
	} ctrl_t;

	typedef struct packed {
		logic hit;
		logic hit_way;
		logic victim_dirty;
		logic lru_way; // way to evict next
	} stat_t;

endpackage : cache_ctrl_pkg

// File: cache_types_pkg.sv
package cache_types_pkg;

	localparam int s_offset = 5; // 32-byte lines
	localparam int s_line = 8 * (2 ** s_offset);

	typedef logic [31:0] word_t;
	typedef logic [s_line-1:0] line_t;

	// address with the byte offset cleared
	function automatic word_t line_base(word_t addr);
		return {addr[31:s_offset], {s_offset{1'b0}}};
	endfunction

	// tag field, right aligned in a full word
	function automatic word_t addr_tag(word_t addr, int s_index);
		return addr >> (s_offset + s_index);
	endfunction

	// set index field, right aligned
	function automatic word_t addr_index(word_t addr, int s_index);
		word_t mask;
		mask = (word_t'(1) << s_index) - word_t'(1);
		return (addr >> s_offset) & mask;
	endfunction

	// rebuild a line address from tag and set index
	function automatic word_t join_addr(word_t tag, word_t index, int s_index);
		word_t addr;
		addr = (tag << (s_offset + s_index)) | (index << s_offset);
		return addr;
	endfunction

endpackage : cache_types_pkg
